// ==== Bender.yml ====
package:
  name: vdma_write

sources:
  - hw/vdma_pkg.sv
  - hw/pixel_packer.sv
  - hw/beat_fifo.sv
  - hw/burst_scheduler.sv
  - hw/axi_burst_writer.sv
  - hw/vdma_write.sv
  - target: test
    files:
      - dv/vdma_write_tb.sv

// ==== dv/vdma_write_tb.sv ====
// directed testbench for the video frame writer
// drives pixel frames, models an AXI4 write slave with random stalls and checks every burst
`timescale 1ns/1ns

module vdma_write_tb;
    import vdma_pkg::*;

    localparam int WAIT_LIMIT = 20000;

    logic                  clock;
    logic                  rst_n;
    logic                  enable;
    addr_t                 baseaddr;
    logic                  vsync;
    logic                  de;
    pixel_t                idata;
    logic                  fifo_almost_full;
    logic [ID_W-1:0]       axi_awid;
    addr_t                 axi_awaddr;
    len_t                  axi_awlen;
    logic [2:0]            axi_awsize;
    logic [1:0]            axi_awburst;
    logic                  axi_awvalid;
    logic                  axi_awready;
    beat_data_t            axi_wdata;
    logic [BEAT_BYTES-1:0] axi_wstrb;
    logic                  axi_wlast;
    logic                  axi_wvalid;
    logic                  axi_wready;
    logic                  axi_bready;
    logic [ID_W-1:0]       axi_bid;
    logic [1:0]            axi_bresp;
    logic                  axi_bvalid;

    // traffic seen by the slave model
    addr_t      aw_addr_q[$];
    len_t       aw_len_q[$];
    len_t       aw_size_q[$];
    len_t       aw_burst_q[$];
    len_t       aw_id_q[$];
    beat_data_t w_data_q[$];
    bit         w_last_q[$];
    int         b_done;
    int         b_pending;

    // slave stall state
    int          max_delay;
    logic [31:0] delay_rng;
    int          aw_wait;
    int          w_wait;
    int          b_wait;
    logic        b_fire;
    logic        aw_hold;
    logic        w_hold;
    addr_t       aw_addr_hold;
    beat_data_t  w_data_hold;
    logic        w_last_hold;

    // stimulus and scoreboard
    logic [31:0] pix_rng;
    beat_data_t  exp_beats[$];
    addr_t       cur_base;
    // source saw almost-full and held off
    logic        af_seen;
    int          check_errors;
    int          protocol_errors;
    int          timeouts;
    logic        timed_out;

    vdma_write uut (
        .clock            (clock),
        .rst_n            (rst_n),
        .enable           (enable),
        .baseaddr         (baseaddr),
        .vsync            (vsync),
        .de               (de),
        .idata            (idata),
        .fifo_almost_full (fifo_almost_full),
        .axi_awid         (axi_awid),
        .axi_awaddr       (axi_awaddr),
        .axi_awlen        (axi_awlen),
        .axi_awsize       (axi_awsize),
        .axi_awburst      (axi_awburst),
        .axi_awvalid      (axi_awvalid),
        .axi_awready      (axi_awready),
        .axi_wdata        (axi_wdata),
        .axi_wstrb        (axi_wstrb),
        .axi_wlast        (axi_wlast),
        .axi_wvalid       (axi_wvalid),
        .axi_wready       (axi_wready),
        .axi_bready       (axi_bready),
        .axi_bid          (axi_bid),
        .axi_bresp        (axi_bresp),
        .axi_bvalid       (axi_bvalid)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // stall length for the next ready or bvalid
    function automatic int next_delay();
        delay_rng = xorshift32(delay_rng);
        return int'(delay_rng % (max_delay + 1));
    endfunction

    task automatic check_addr(input addr_t got, input addr_t exp, input string name);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_len(input len_t got, input len_t exp, input string name);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_data(input beat_data_t got, input beat_data_t exp, input string name);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_strb(input logic [BEAT_BYTES-1:0] got,
                              input logic [BEAT_BYTES-1:0] exp, input string name);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string name);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0b expected %0b", $time, name, got, exp);
            check_errors++;
        end
    endtask

    // slave model; ready decided at the falling edge, so valid and ready
    // seen here are exactly what the next rising edge samples
    always @(negedge clock) begin
        if (!rst_n) begin
            axi_awready = 1'b0;
            axi_wready  = 1'b0;
            axi_bvalid  = 1'b0;
            aw_hold     = 1'b0;
            w_hold      = 1'b0;
            b_fire      = 1'b0;
            b_pending   = 0;
            aw_wait     = 0;
            w_wait      = 0;
            b_wait      = 0;
        end else begin
            // B before W so a response never precedes its last beat
            if (b_fire) begin
                axi_bvalid = 1'b0;
                b_fire     = 1'b0;
                b_wait     = next_delay();
            end
            if (!axi_bvalid && b_pending > 0) begin
                if (b_wait == 0) begin
                    axi_bvalid = 1'b1;
                end else begin
                    b_wait--;
                end
            end
            if (axi_bvalid && axi_bready) begin
                b_fire = 1'b1;
                b_pending--;
                b_done++;
            end

            // AW, valid and address must hold through a stall
            if (aw_hold && (!axi_awvalid || axi_awaddr !== aw_addr_hold)) begin
                $display("awvalid or awaddr changed before the AW handshake at %0t", $time);
                protocol_errors++;
            end
            axi_awready = 1'b0;
            aw_hold     = 1'b0;
            if (axi_awvalid) begin
                if (aw_wait == 0) begin
                    axi_awready = 1'b1;
                    aw_addr_q.push_back(axi_awaddr);
                    aw_len_q.push_back(axi_awlen);
                    aw_size_q.push_back(len_t'(axi_awsize));
                    aw_burst_q.push_back(len_t'(axi_awburst));
                    aw_id_q.push_back(len_t'(axi_awid));
                    aw_wait = next_delay();
                end else begin
                    aw_wait--;
                    aw_hold      = 1'b1;
                    aw_addr_hold = axi_awaddr;
                end
            end

            // W, same rule for data and wlast
            if (w_hold && (!axi_wvalid || axi_wdata !== w_data_hold ||
                           axi_wlast !== w_last_hold)) begin
                $display("wvalid, wdata or wlast changed before the W handshake at %0t", $time);
                protocol_errors++;
            end
            axi_wready = 1'b0;
            w_hold     = 1'b0;
            if (axi_wvalid) begin
                if (w_wait == 0) begin
                    axi_wready = 1'b1;
                    w_data_q.push_back(axi_wdata);
                    w_last_q.push_back(axi_wlast);
                    // every beat is a full 16-byte word
                    check_strb(axi_wstrb, {BEAT_BYTES{1'b1}}, "wstrb");
                    if (axi_wlast) begin
                        b_pending++;
                    end
                    w_wait = next_delay();
                end else begin
                    w_wait--;
                    w_hold      = 1'b1;
                    w_data_hold = axi_wdata;
                    w_last_hold = axi_wlast;
                end
            end
        end
    end

    // one vsync pulse; enable is sampled with the rising edge
    task automatic drive_vsync(input logic en);
        @(negedge clock);
        de     = 1'b0;
        vsync  = 1'b1;
        enable = en;
        @(negedge clock);
        vsync = 1'b0;
    endtask

    // streams random pixels and builds the expected beats alongside
    task automatic feed_frame(input int npix);
        pixel_t     pix;
        beat_data_t word;
        int         lane;
        int         stall;
        word = '0;
        lane = 0;
        for (int i = 0; i < npix && !timed_out; i++) begin
            pix_rng = xorshift32(pix_rng);
            pix     = pix_rng[PIX_W-1:0];
            @(negedge clock);
            stall = 0;
            // source holds off while the FIFO is nearly full
            while (fifo_almost_full && stall < WAIT_LIMIT) begin
                af_seen = 1'b1;
                de      = 1'b0;
                @(negedge clock);
                stall++;
            end
            if (stall >= WAIT_LIMIT) begin
                $display("timeout: fifo_almost_full stayed high at %0t", $time);
                timeouts++;
                timed_out = 1'b1;
            end else begin
                de    = 1'b1;
                idata = pix;
                word[lane*LANE_W +: LANE_W] = {{(LANE_W-PIX_W){1'b0}}, pix};
                lane++;
                if (lane == PIX_PER_BEAT) begin
                    exp_beats.push_back(word);
                    word = '0;
                    lane = 0;
                end
            end
        end
        // flush beat, partial or all zero when the count was a multiple of four
        exp_beats.push_back(word);
    endtask

    task automatic wait_bursts(input int target);
        int cycles;
        cycles = 0;
        while (b_done < target && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (b_done < target) begin
            $display("timeout: only %0d of %0d write responses arrived", b_done, target);
            timeouts++;
            timed_out = 1'b1;
        end
        // ack follows B by one cycle, address reload one more
        repeat (4) @(negedge clock);
    endtask

    // expected split is full bursts of BURST_LEN then the remainder
    task automatic score_frame(input addr_t base);
        addr_t addr;
        int    idx;
        int    blen;
        int    left;
        addr = base;
        idx  = 0;
        left = exp_beats.size();
        while (left > 0) begin
            blen = (left > BURST_LEN) ? BURST_LEN : left;
            if (aw_addr_q.size() == 0 || w_data_q.size() < blen) begin
                $display("burst of %0d beats at %h was not written", blen, addr);
                check_errors++;
                left = 0;
            end else begin
                check_addr(aw_addr_q.pop_front(), addr, "awaddr");
                check_len(aw_len_q.pop_front(), len_t'(blen - 1), "awlen");
                check_len(aw_size_q.pop_front(), len_t'(AXI_SIZE), "awsize");
                check_len(aw_burst_q.pop_front(), len_t'(AXI_BURST_INCR), "awburst");
                check_len(aw_id_q.pop_front(), len_t'(AXI_ID), "awid");
                for (int j = 0; j < blen; j++) begin
                    check_data(w_data_q.pop_front(), exp_beats[idx],
                               $sformatf("wdata beat %0d", idx));
                    check_flag(w_last_q.pop_front(), j == blen - 1, "wlast");
                    idx++;
                end
                addr = addr + addr_t'(blen * BEAT_BYTES);
                left = left - blen;
            end
        end
        // every beat is written out, so the FIFO is empty again
        check_flag(fifo_almost_full, 1'b0, "fifo_almost_full");
        expect_no_traffic();
    endtask

    task automatic expect_no_traffic();
        if (aw_addr_q.size() != 0 || w_data_q.size() != 0) begin
            $display("unexpected AW or W traffic: %0d addresses, %0d beats",
                     aw_addr_q.size(), w_data_q.size());
            check_errors++;
            aw_addr_q.delete();
            aw_len_q.delete();
            aw_size_q.delete();
            aw_burst_q.delete();
            aw_id_q.delete();
            w_data_q.delete();
            w_last_q.delete();
        end
    endtask

    // one enabled frame; next_base is what the last burst reloads
    task automatic run_frame(input int npix, input addr_t next_base);
        int start;
        int nbursts;
        exp_beats.delete();
        start    = b_done;
        baseaddr = next_base;
        drive_vsync(1'b1);
        feed_frame(npix);
        drive_vsync(1'b0);
        nbursts = (exp_beats.size() + BURST_LEN - 1) / BURST_LEN;
        wait_bursts(start + nbursts);
        if (!timed_out) begin
            score_frame(cur_base);
        end
        cur_base = next_base;
    endtask

    // 128 pixels, two full bursts and a one-beat zero tail
    task automatic full_burst_test();
        run_frame(128, 32'h1000_4000);
    endtask

    // 70 pixels at the reloaded base, 16 beats then 2
    task automatic tail_test();
        run_frame(70, 32'h2000_0000);
    endtask

    // frame opened with enable low, nothing reaches AXI
    task automatic enable_test();
        int start;
        start = b_done;
        exp_beats.delete();
        drive_vsync(1'b0);
        feed_frame(40);
        drive_vsync(1'b0);
        repeat (100) @(negedge clock);
        expect_no_traffic();
        if (b_done != start) begin
            $display("write response seen for a disabled frame");
            check_errors++;
        end
    endtask

    // long stalls; the larger frame also drives the FIFO into almost-full
    task automatic backpressure_test();
        max_delay = 12;
        run_frame(70, 32'h3000_0000);
        if (!timed_out) begin
            af_seen = 1'b0;
            run_frame(1000, 32'h4000_0000);
            if (!timed_out) begin
                check_flag(af_seen, 1'b1, "fifo_almost_full seen");
            end
        end
        max_delay = 2;
    endtask

    initial begin
        rst_n           = 1'b0;
        enable          = 1'b0;
        baseaddr        = 32'h1000_0000;
        vsync           = 1'b0;
        de              = 1'b0;
        idata           = '0;
        axi_awready     = 1'b0;
        axi_wready      = 1'b0;
        axi_bvalid      = 1'b0;
        axi_bid         = '0;
        axi_bresp       = 2'b00;
        pix_rng         = 32'd32;
        delay_rng       = 32'd32;
        max_delay       = 2;
        b_done          = 0;
        cur_base        = 32'h1000_0000;
        af_seen         = 1'b0;
        check_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        timed_out       = 1'b0;
        repeat (2) @(negedge clock);
        rst_n = 1'b1;

        full_burst_test();
        if (!timed_out) begin
            tail_test();
        end
        if (!timed_out) begin
            enable_test();
        end
        if (!timed_out) begin
            backpressure_test();
        end

        $display("errors: %0d check, %0d protocol, %0d timeout",
                 check_errors, protocol_errors, timeouts);
        if (check_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== hw/axi_burst_writer.sv ====
// AXI4 write master for one burst command at a time
// issues AW, streams W beats straight from the FIFO head, acks the command after B
`timescale 1ns/1ns

module axi_burst_writer (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           cmd_req,
    input  vdma_pkg::burst_cmd_t           cmd,
    output logic                           cmd_ack,
    input  vdma_pkg::beat_t                head,
    input  logic                           empty,
    output logic                           pop,
    output logic [vdma_pkg::ID_W-1:0]      awid,
    output vdma_pkg::addr_t                awaddr,
    output vdma_pkg::len_t                 awlen,
    output logic [2:0]                     awsize,
    output logic [1:0]                     awburst,
    output logic                           awvalid,
    input  logic                           awready,
    output vdma_pkg::beat_data_t           wdata,
    output logic [vdma_pkg::BEAT_BYTES-1:0] wstrb,
    output logic                           wlast,
    output logic                           wvalid,
    input  logic                           wready,
    output logic                           bready,
    input  logic [vdma_pkg::ID_W-1:0]      bid,
    input  logic [1:0]                     bresp,
    input  logic                           bvalid
);
    import vdma_pkg::*;

    wr_state_e  state;
    burst_cmd_t cmd_q;
    len_t       beat_cnt;

    // fixed attributes
    assign awid    = ID_W'(AXI_ID);
    assign awsize  = 3'(AXI_SIZE);
    assign awburst = 2'(AXI_BURST_INCR);
    assign wstrb   = '1;

    assign awaddr = cmd_q.addr;
    assign awlen  = cmd_q.len;

    // W comes straight off the FIFO head
    assign wvalid = (state == WR_DATA) && !empty;
    assign wdata  = head.data;
    assign wlast  = (beat_cnt == cmd_q.len);
    assign pop    = wvalid && wready;
    assign bready = (state == WR_RESP);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state    <= WR_IDLE;
            awvalid  <= 1'b0;
            cmd_ack  <= 1'b0;
            beat_cnt <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (cmd_req) begin
                        cmd_q   <= cmd;
                        awvalid <= 1'b1;
                        state   <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (awready) begin
                        awvalid  <= 1'b0;
                        beat_cnt <= '0;
                        state    <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (pop) begin
                        if (wlast) begin
                            state <= WR_RESP;
                        end else begin
                            beat_cnt <= beat_cnt + len_t'(1);
                        end
                    end
                end
                WR_RESP: begin
                    // response code is not checked, any B completes
                    if (bvalid) begin
                        cmd_ack <= 1'b1;
                        state   <= WR_ACK;
                    end
                end
                WR_ACK: begin
                    // four-phase, wait for req to fall
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= WR_IDLE;
                    end
                end
                default: begin
                    state   <= WR_IDLE;
                    awvalid <= 1'b0;
                    cmd_ack <= 1'b0;
                end
            endcase
        end
    end

    // scheduler must cut bursts exactly at frame ends
    property p_last_on_wlast;
        @(posedge clock) disable iff (!rst_n)
            pop && head.last |-> wlast;
    endproperty
    a_last_on_wlast: assert property (p_last_on_wlast);

endmodule

// ==== hw/beat_fifo.sv ====
// show-ahead FIFO of beats between the packer and the AXI writer
// head is valid whenever empty is low; almost_full throttles the pixel source
`timescale 1ns/1ns

module beat_fifo (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            push,
    input  vdma_pkg::beat_t push_beat,
    input  logic            pop,
    output vdma_pkg::beat_t head,
    output logic            empty,
    output vdma_pkg::cnt_t  count,
    output logic            almost_full
);
    import vdma_pkg::*;

    beat_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    cnt_t             count_next;

    // storage, no reset
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + cnt_t'(1);
        end else if (pop && !push) begin
            count_next = count - cnt_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            // pointers wrap naturally at depth 64
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count       <= count_next;
            almost_full <= (count_next >= cnt_t'(ALMOST_FULL_LVL));
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);

    // source must respect almost_full early enough
    property p_no_overflow;
        @(posedge clock) disable iff (!rst_n)
            push |-> (count != cnt_t'(FIFO_DEPTH)) || pop;
    endproperty
    a_no_overflow: assert property (p_no_overflow);

    property p_no_underflow;
        @(posedge clock) disable iff (!rst_n)
            pop |-> !empty;
    endproperty
    a_no_underflow: assert property (p_no_underflow);

endmodule

// ==== hw/burst_scheduler.sv ====
// decides full and tail bursts from the FIFO level and owns the frame address
// commands go to the writer over a four-phase req/ack handshake
`timescale 1ns/1ns

module burst_scheduler (
    input  logic                 clock,
    input  logic                 rst_n,
    input  vdma_pkg::addr_t      baseaddr,
    input  vdma_pkg::cnt_t       count,
    input  logic                 frame_last_push,
    output logic                 cmd_req,
    output vdma_pkg::burst_cmd_t cmd,
    input  logic                 cmd_ack
);
    import vdma_pkg::*;

    sched_state_e state;
    addr_t        frame_addr;
    // frame ends buffered but not yet written
    cnt_t         pend_cnt;
    // beats up to and including the oldest last beat
    cnt_t         to_last;
    logic         cmd_has_last;
    logic         want_full;
    logic         want_tail;
    logic         hit_last;
    cnt_t         pend_dec;

    // count is frozen in idle since nothing pops without a command
    // a pending end is assumed to be the newest beat buffered
    assign to_last   = (pend_cnt != '0) ? count : '0;
    assign want_full = (count >= cnt_t'(BURST_LEN));
    assign want_tail = (pend_cnt != '0) && (count != '0);
    // a full burst may still end exactly on the last beat
    assign hit_last  = (pend_cnt != '0) && (to_last <= cnt_t'(BURST_LEN));

    assign pend_dec = (state == SCHED_REQ && cmd_ack && cmd_has_last) ? cnt_t'(1) : '0;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state        <= SCHED_IDLE;
            cmd_req      <= 1'b0;
            cmd_has_last <= 1'b0;
            pend_cnt     <= '0;
            frame_addr   <= baseaddr;
        end else begin
            pend_cnt <= pend_cnt + cnt_t'(frame_last_push) - pend_dec;
            case (state)
                SCHED_IDLE: begin
                    // old ack must be gone before a new req
                    if (!cmd_ack && (want_full || want_tail)) begin
                        cmd.addr     <= frame_addr;
                        cmd_has_last <= hit_last;
                        if (want_full) begin
                            cmd.len <= len_t'(BURST_LEN - 1);
                        end else begin
                            cmd.len <= len_t'(count - cnt_t'(1));
                        end
                        cmd_req <= 1'b1;
                        state   <= SCHED_REQ;
                    end
                end
                SCHED_REQ: begin
                    // ack means B done, every beat popped
                    if (cmd_ack) begin
                        cmd_req <= 1'b0;
                        state   <= SCHED_RELEASE;
                        if (cmd_has_last) begin
                            frame_addr <= baseaddr;
                        end else begin
                            frame_addr <= frame_addr +
                                addr_t'((32'(cmd.len) + 32'd1) * BEAT_BYTES);
                        end
                    end
                end
                SCHED_RELEASE: begin
                    if (!cmd_ack) begin
                        state <= SCHED_IDLE;
                    end
                end
                default: begin
                    state   <= SCHED_IDLE;
                    cmd_req <= 1'b0;
                end
            endcase
        end
    end

    // writer samples cmd any time while req is up
    property p_cmd_stable;
        @(posedge clock) disable iff (!rst_n)
            cmd_req && $past(cmd_req) |-> $stable(cmd);
    endproperty
    a_cmd_stable: assert property (p_cmd_stable);

endmodule

// ==== hw/pixel_packer.sv ====
// packs 24-bit pixels into 128-bit beats, four 32-bit lanes per beat
// frames open on a vsync rising edge when enable is high; the next edge closes them
`timescale 1ns/1ns

module pixel_packer (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             enable,
    input  logic             vsync,
    input  logic             de,
    input  vdma_pkg::pixel_t idata,
    output logic             push,
    output vdma_pkg::beat_t  push_beat,
    output logic             frame_last_push
);
    import vdma_pkg::*;

    logic       vsync_d;
    logic       vs_rise;
    logic       frame_open;
    logic [1:0] lane;
    beat_data_t partial;
    beat_data_t word_next;
    logic       take_pix;

    assign vs_rise = vsync & ~vsync_d;
    // pixels landing on the vsync edge belong to no frame
    assign take_pix = de & frame_open & ~vs_rise;

    // partial word with the new pixel dropped into its lane
    always_comb begin
        word_next = partial;
        word_next[lane*LANE_W +: LANE_W] = {{(LANE_W-PIX_W){1'b0}}, idata};
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            vsync_d    <= 1'b0;
            frame_open <= 1'b0;
            lane       <= '0;
            partial    <= '0;
            push       <= 1'b0;
        end else begin
            vsync_d <= vsync;
            push    <= 1'b0;
            if (vs_rise) begin
                // close current frame, open next only when enabled
                frame_open <= enable;
                lane       <= '0;
                partial    <= '0;
                if (frame_open) begin
                    // flush; missing lanes are already zero
                    push           <= 1'b1;
                    push_beat.data <= partial;
                    push_beat.last <= 1'b1;
                end
            end else if (take_pix) begin
                lane <= lane + 2'd1;
                if (lane == 2'd3) begin
                    push           <= 1'b1;
                    push_beat.data <= word_next;
                    push_beat.last <= 1'b0;
                    partial        <= '0;
                end else begin
                    partial <= word_next;
                end
            end
        end
    end

    // scheduler counts frame ends from this
    assign frame_last_push = push & push_beat.last;

endmodule

// ==== hw/vdma_pkg.sv ====
// shared sizes, AXI constants and types for the video frame writer
// every module imports this package; nothing here is parameterized per instance
package vdma_pkg;

    // pixel and bus geometry
    localparam int PIX_W        = 24;
    localparam int LANE_W       = 32;
    localparam int PIX_PER_BEAT = 4;
    localparam int BEAT_W       = 128;
    localparam int ADDR_W       = 32;
    localparam int BEAT_BYTES   = 16;

    // beats in a full burst
    localparam int BURST_LEN = 16;

    // beat buffer
    localparam int FIFO_DEPTH      = 64;
    localparam int PTR_W           = 6;
    localparam int CNT_W           = 7;
    localparam int ALMOST_FULL_LVL = 56;

    // fixed AXI write attributes
    localparam int ID_W           = 4;
    localparam int AXI_ID         = 0;
    localparam int AXI_SIZE       = 4;
    localparam int AXI_BURST_INCR = 1;

    typedef logic [PIX_W-1:0]  pixel_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [7:0]        len_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [BEAT_W-1:0] beat_data_t;

    // one bus word plus the end-of-frame marker
    typedef struct packed {
        beat_data_t data;
        logic       last;
    } beat_t;

    // burst command, len in awlen form (beats minus one)
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } burst_cmd_t;

    typedef enum logic [1:0] {
        SCHED_IDLE,
        SCHED_REQ,
        SCHED_RELEASE
    } sched_state_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_ACK
    } wr_state_e;

endpackage

// ==== hw/vdma_write.sv ====
// top of the frame writer: packer, beat FIFO, burst scheduler and AXI writer
// single clock; pixel source must hold off de while fifo_almost_full is high
`timescale 1ns/1ns

module vdma_write (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            enable,
    input  vdma_pkg::addr_t                 baseaddr,
    input  logic                            vsync,
    input  logic                            de,
    input  vdma_pkg::pixel_t                idata,
    output logic                            fifo_almost_full,
    output logic [vdma_pkg::ID_W-1:0]       axi_awid,
    output vdma_pkg::addr_t                 axi_awaddr,
    output vdma_pkg::len_t                  axi_awlen,
    output logic [2:0]                      axi_awsize,
    output logic [1:0]                      axi_awburst,
    output logic                            axi_awvalid,
    input  logic                            axi_awready,
    output vdma_pkg::beat_data_t            axi_wdata,
    output logic [vdma_pkg::BEAT_BYTES-1:0] axi_wstrb,
    output logic                            axi_wlast,
    output logic                            axi_wvalid,
    input  logic                            axi_wready,
    output logic                            axi_bready,
    input  logic [vdma_pkg::ID_W-1:0]       axi_bid,
    input  logic [1:0]                      axi_bresp,
    input  logic                            axi_bvalid
);
    import vdma_pkg::*;

    // packer to FIFO
    logic       push;
    beat_t      push_beat;
    logic       frame_last_push;
    // FIFO to writer and scheduler
    beat_t      head;
    logic       empty;
    cnt_t       count;
    logic       pop;
    // req/ack command path
    logic       cmd_req;
    logic       cmd_ack;
    burst_cmd_t cmd;

    pixel_packer u_packer (
        .clock           (clock),
        .rst_n           (rst_n),
        .enable          (enable),
        .vsync           (vsync),
        .de              (de),
        .idata           (idata),
        .push            (push),
        .push_beat       (push_beat),
        .frame_last_push (frame_last_push)
    );

    beat_fifo u_fifo (
        .clock       (clock),
        .rst_n       (rst_n),
        .push        (push),
        .push_beat   (push_beat),
        .pop         (pop),
        .head        (head),
        .empty       (empty),
        .count       (count),
        .almost_full (fifo_almost_full)
    );

    burst_scheduler u_sched (
        .clock           (clock),
        .rst_n           (rst_n),
        .baseaddr        (baseaddr),
        .count           (count),
        .frame_last_push (frame_last_push),
        .cmd_req         (cmd_req),
        .cmd             (cmd),
        .cmd_ack         (cmd_ack)
    );

    axi_burst_writer u_writer (
        .clock   (clock),
        .rst_n   (rst_n),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack),
        .head    (head),
        .empty   (empty),
        .pop     (pop),
        .awid    (axi_awid),
        .awaddr  (axi_awaddr),
        .awlen   (axi_awlen),
        .awsize  (axi_awsize),
        .awburst (axi_awburst),
        .awvalid (axi_awvalid),
        .awready (axi_awready),
        .wdata   (axi_wdata),
        .wstrb   (axi_wstrb),
        .wlast   (axi_wlast),
        .wvalid  (axi_wvalid),
        .wready  (axi_wready),
        .bready  (axi_bready),
        .bid     (axi_bid),
        .bresp   (axi_bresp),
        .bvalid  (axi_bvalid)
    );

endmodule

// ==== list.f ====
hw/vdma_pkg.sv
hw/pixel_packer.sv
hw/beat_fifo.sv
hw/burst_scheduler.sv
hw/axi_burst_writer.sv
hw/vdma_write.sv
dv/vdma_write_tb.sv
